/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // lui passes the immediate through
    ALU_PASS_B
  } alu_op_e;

  // register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // register-immediate layout
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  typedef struct packed {
    alu_op_e         alu_op;
    logic            use_imm;
    logic [XLEN-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            wen;
    logic            illegal;
    // always zero
    logic            pad;
  } dec_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic [XLEN-1:0] value;
    logic            wen;
    logic            illegal;
  } res_t;

endpackage

`default_nettype wire

/* logic/stage_if.sv */
`default_nettype none

// one valid/ready hop between two pipeline stages
interface stage_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t payload;

  // high on the edge where the item moves
  logic     xfer;

  assign xfer = valid && ready;

  modport producer (
    output valid,
    output payload,
    input  ready
  );

  modport consumer (
    input  valid,
    input  payload,
    input  xfer,
    output ready
  );

endinterface

`default_nettype wire

/* logic/inst_decode.sv */
`default_nettype none

module inst_decode (
  input  logic          clk,
  input  logic          i_reset,
  input  logic          i_valid,
  input  rv_pkg::inst_u i_inst,
  output logic          o_ready,
  stage_if.producer     dec_bus
);

  rv_pkg::dec_t dec_d;
  logic         is_op;
  logic         funct7_ok;
  logic         check_funct7;

  assign is_op = (i_inst.r.opcode == rv_pkg::OPC_OP);

  // only 0000000 and 0100000 exist, the latter for sub and sra/srai
  assign funct7_ok = (i_inst.r.funct7 == 7'h00) ||
                     ((i_inst.r.funct7 == 7'h20) &&
                      ((is_op && i_inst.r.funct3 == 3'd0) || i_inst.r.funct3 == 3'd5));

  // OP-IMM shifts carry funct7 in imm[11:5], other OP-IMM ops do not
  assign check_funct7 = is_op || (i_inst.r.funct3 == 3'd1) || (i_inst.r.funct3 == 3'd5);

  always_comb begin
    dec_d         = '0;
    dec_d.rs1     = i_inst.r.rs1;
    dec_d.rs2     = i_inst.r.rs2;
    dec_d.rd      = i_inst.r.rd;
    dec_d.alu_op  = rv_pkg::ALU_ADD;
    dec_d.wen     = 1'b1;

    case (i_inst.r.opcode)
      rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
        dec_d.use_imm = !is_op;
        dec_d.imm     = {{(rv_pkg::XLEN-12){i_inst.i.imm12[11]}}, i_inst.i.imm12};
        case (i_inst.r.funct3)
          3'd0: dec_d.alu_op = (is_op && i_inst.r.funct7[5]) ? rv_pkg::ALU_SUB
                                                             : rv_pkg::ALU_ADD;
          3'd1: dec_d.alu_op = rv_pkg::ALU_SLL;
          3'd2: dec_d.alu_op = rv_pkg::ALU_SLT;
          3'd3: dec_d.alu_op = rv_pkg::ALU_SLTU;
          3'd4: dec_d.alu_op = rv_pkg::ALU_XOR;
          3'd5: dec_d.alu_op = i_inst.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'd6: dec_d.alu_op = rv_pkg::ALU_OR;
          default: dec_d.alu_op = rv_pkg::ALU_AND;
        endcase
        dec_d.illegal = check_funct7 && !funct7_ok;
      end
      rv_pkg::OPC_LUI: begin
        dec_d.use_imm = 1'b1;
        dec_d.alu_op  = rv_pkg::ALU_PASS_B;
        // upper 20 bits span funct7..funct3 of the r view
        dec_d.imm     = {i_inst.r.funct7, i_inst.r.rs2, i_inst.r.rs1, i_inst.r.funct3,
                         12'h000};
      end
      default: begin
        dec_d.illegal = 1'b1;
      end
    endcase

    // illegal items retire with value 0 and no write
    if (dec_d.illegal) begin
      dec_d.alu_op  = rv_pkg::ALU_PASS_B;
      dec_d.use_imm = 1'b1;
      dec_d.imm     = '0;
      dec_d.wen     = 1'b0;
    end
  end

  // take a new word when the output slot is free or draining
  assign o_ready = !dec_bus.valid || dec_bus.ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      dec_bus.valid <= 1'b0;
    end else if (o_ready) begin
      dec_bus.valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_ready && i_valid) begin
      dec_bus.payload <= dec_d;
    end
  end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file #(
  parameter logic [31:0] RESET_VALUE = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic [4:0]              i_raddr_a,
  input  logic [4:0]              i_raddr_b,
  output logic [rv_pkg::XLEN-1:0] o_rdata_a,
  output logic [rv_pkg::XLEN-1:0] o_rdata_b,
  input  logic                    i_wen,
  input  logic [4:0]              i_waddr,
  input  logic [rv_pkg::XLEN-1:0] i_wdata
);

  // x1..x31, x0 has no storage
  logic [rv_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= RESET_VALUE;
      end
    end else if (i_wen && (i_waddr != 5'd0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // asynchronous read, x0 reads as zero
  assign o_rdata_a = (i_raddr_a == 5'd0) ? '0 : regs[i_raddr_a];
  assign o_rdata_b = (i_raddr_b == 5'd0) ? '0 : regs[i_raddr_b];

endmodule

`default_nettype wire

/* logic/alu_execute.sv */
`default_nettype none

module alu_execute (
  input  logic                    clk,
  input  logic                    i_reset,
  stage_if.consumer               dec_bus,
  stage_if.producer               exe_bus,
  output logic [4:0]              o_raddr_a,
  output logic [4:0]              o_raddr_b,
  input  logic [rv_pkg::XLEN-1:0] i_rdata_a,
  input  logic [rv_pkg::XLEN-1:0] i_rdata_b
);

  rv_pkg::dec_t            dec;
  rv_pkg::res_t            res_d;
  logic                    fwd_a;
  logic                    fwd_b;
  logic                    fwd_ok;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] rs2_val;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;
  logic [rv_pkg::XLEN-1:0] alu_out;

  assign dec = dec_bus.payload;

  assign o_raddr_a = dec.rs1;
  assign o_raddr_b = dec.rs2;

  // the item in our output register is the only one not yet in the register file
  assign fwd_ok = exe_bus.valid && exe_bus.payload.wen && (exe_bus.payload.rd != 5'd0);
  assign fwd_a  = fwd_ok && (exe_bus.payload.rd == dec.rs1);
  assign fwd_b  = fwd_ok && (exe_bus.payload.rd == dec.rs2);

  assign op_a    = fwd_a ? exe_bus.payload.value : i_rdata_a;
  assign rs2_val = fwd_b ? exe_bus.payload.value : i_rdata_b;
  assign op_b    = dec.use_imm ? dec.imm : rs2_val;

  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:    alu_out = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_out = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_out = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU:   alu_out = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_out = op_a >> shamt;
      rv_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:     alu_out = op_a | op_b;
      rv_pkg::ALU_AND:    alu_out = op_a & op_b;
      rv_pkg::ALU_PASS_B: alu_out = op_b;
      default:            alu_out = '0;
    endcase
  end

  always_comb begin
    res_d.rd      = dec.rd;
    res_d.value   = alu_out;
    res_d.wen     = dec.wen;
    res_d.illegal = dec.illegal;
  end

  assign dec_bus.ready = !exe_bus.valid || exe_bus.ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      exe_bus.valid <= 1'b0;
    end else if (dec_bus.ready) begin
      exe_bus.valid <= dec_bus.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_bus.xfer) begin
      exe_bus.payload <= res_d;
    end
  end

endmodule

`default_nettype wire

/* logic/writeback_stage.sv */
`default_nettype none

module writeback_stage (
  input  logic                    clk,
  input  logic                    i_reset,
  stage_if.consumer               exe_bus,
  output logic                    o_wen,
  output logic [4:0]              o_waddr,
  output logic [rv_pkg::XLEN-1:0] o_wdata,
  output logic                    o_valid,
  output logic [4:0]              o_rd,
  output logic [rv_pkg::XLEN-1:0] o_value,
  output logic                    o_illegal,
  input  logic                    i_ready
);

  rv_pkg::res_t wb_q;

  assign exe_bus.ready = !o_valid || i_ready;

  // register file is written on the same edge the item is captured here
  assign o_wen   = exe_bus.xfer && exe_bus.payload.wen && (exe_bus.payload.rd != 5'd0);
  assign o_waddr = exe_bus.payload.rd;
  assign o_wdata = exe_bus.payload.value;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (exe_bus.ready) begin
      o_valid <= exe_bus.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_bus.xfer) begin
      wb_q <= exe_bus.payload;
    end
  end

  assign o_rd      = wb_q.rd;
  assign o_value   = wb_q.value;
  assign o_illegal = wb_q.illegal;

endmodule

`default_nettype wire

/* logic/int_core.sv */
`default_nettype none

module int_core #(
  parameter logic [31:0] RESET_VALUE = 32'h0000_1000
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_inst_valid,
  input  logic [31:0]             i_inst,
  output logic                    o_inst_ready,
  output logic                    o_wb_valid,
  output logic [4:0]              o_wb_rd,
  output logic [rv_pkg::XLEN-1:0] o_wb_value,
  output logic                    o_wb_illegal,
  input  logic                    i_wb_ready
);

  logic [4:0]              raddr_a;
  logic [4:0]              raddr_b;
  logic [rv_pkg::XLEN-1:0] rdata_a;
  logic [rv_pkg::XLEN-1:0] rdata_b;
  logic                    rf_wen;
  logic [4:0]              rf_waddr;
  logic [rv_pkg::XLEN-1:0] rf_wdata;

  stage_if #(.payload_t(rv_pkg::dec_t)) dec_bus ();
  stage_if #(.payload_t(rv_pkg::res_t)) exe_bus ();

  inst_decode u_decode (
    .clk     (clk),
    .i_reset (i_reset),
    .i_valid (i_inst_valid),
    .i_inst  (i_inst),
    .o_ready (o_inst_ready),
    .dec_bus (dec_bus.producer)
  );

  reg_file #(
    .RESET_VALUE (RESET_VALUE)
  ) u_reg_file (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_raddr_a (raddr_a),
    .i_raddr_b (raddr_b),
    .o_rdata_a (rdata_a),
    .o_rdata_b (rdata_b),
    .i_wen     (rf_wen),
    .i_waddr   (rf_waddr),
    .i_wdata   (rf_wdata)
  );

  alu_execute u_execute (
    .clk       (clk),
    .i_reset   (i_reset),
    .dec_bus   (dec_bus.consumer),
    .exe_bus   (exe_bus.producer),
    .o_raddr_a (raddr_a),
    .o_raddr_b (raddr_b),
    .i_rdata_a (rdata_a),
    .i_rdata_b (rdata_b)
  );

  writeback_stage u_writeback (
    .clk       (clk),
    .i_reset   (i_reset),
    .exe_bus   (exe_bus.consumer),
    .o_wen     (rf_wen),
    .o_waddr   (rf_waddr),
    .o_wdata   (rf_wdata),
    .o_valid   (o_wb_valid),
    .o_rd      (o_wb_rd),
    .o_value   (o_wb_value),
    .o_illegal (o_wb_illegal),
    .i_ready   (i_wb_ready)
  );

endmodule

`default_nettype wire

/* dv/int_core_chk.sv */
`default_nettype none

module int_core_chk (
  input logic        clk,
  input logic        i_reset,
  input logic        o_inst_ready,
  input logic        o_wb_valid,
  input logic [4:0]  o_wb_rd,
  input logic [31:0] o_wb_value,
  input logic        o_wb_illegal,
  input logic        i_wb_ready
);

  // a stalled result stays offered
  a_valid_held: assert property (@(posedge clk) disable iff (i_reset)
    (o_wb_valid && !i_wb_ready) |=> o_wb_valid)
    else $error("o_wb_valid dropped before i_wb_ready");

  // and its payload does not move
  a_payload_stable: assert property (@(posedge clk) disable iff (i_reset)
    (o_wb_valid && !i_wb_ready) |=>
      ($stable(o_wb_rd) && $stable(o_wb_value) && $stable(o_wb_illegal)))
    else $error("writeback payload changed while stalled");

  a_reset_empty: assert property (@(posedge clk) i_reset |=> (!o_wb_valid && o_inst_ready))
    else $error("pipeline not empty after reset");

endmodule

bind int_core int_core_chk u_chk (
  .clk          (clk),
  .i_reset      (i_reset),
  .o_inst_ready (o_inst_ready),
  .o_wb_valid   (o_wb_valid),
  .o_wb_rd      (o_wb_rd),
  .o_wb_value   (o_wb_value),
  .o_wb_illegal (o_wb_illegal),
  .i_wb_ready   (i_wb_ready)
);

`default_nettype wire

/* dv/rv_model.svh */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

`default_nettype none

// architectural register file of the model, x0 stays zero
logic [31:0] model_regs [32];

function automatic void load_reset_regs(input logic [31:0] reset_value);
  model_regs[0] = '0;
  for (int i = 1; i < 32; i++) begin
    model_regs[i] = reset_value;
  end
endfunction

// one call per accepted instruction in order
function automatic void step_model(input logic [31:0] inst, output logic [4:0] rd,
                                   output logic [31:0] value, output logic illegal);
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        is_op;
  logic [31:0] a;
  logic [31:0] b;
  opc     = inst[6:0];
  f3      = inst[14:12];
  f7      = inst[31:25];
  rd      = inst[11:7];
  is_op   = (opc == rv_pkg::OPC_OP);
  a       = model_regs[inst[19:15]];
  b       = is_op ? model_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
  value   = '0;
  illegal = 1'b0;
  if (opc == rv_pkg::OPC_LUI) begin
    value = {inst[31:12], 12'h000};
  end else if (is_op || opc == rv_pkg::OPC_OP_IMM) begin
    if ((is_op || f3 == 3'd1 || f3 == 3'd5) && !(f7 == 7'h00 ||
        (f7 == 7'h20 && ((is_op && f3 == 3'd0) || f3 == 3'd5)))) begin
      illegal = 1'b1;
    end else begin
      case (f3)
        3'd0: value = (is_op && f7[5]) ? a - b : a + b;
        3'd1: value = a << b[4:0];
        3'd2: value = {31'd0, $signed(a) < $signed(b)};
        3'd3: value = {31'd0, a < b};
        3'd4: value = a ^ b;
        3'd5: value = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: value = a | b;
        default: value = a & b;
      endcase
    end
  end else begin
    illegal = 1'b1;
  end
  if (!illegal && rd != 5'd0) begin
    model_regs[rd] = value;
  end
endfunction

`default_nettype wire

`endif

/* dv/int_core_tb.sv */
`include "rv_model.svh"

`default_nettype none

module int_core_tb;

  localparam logic [31:0] RESET_VALUE = 32'h8000_0123;
  localparam int          NUM_INST    = 1500;
  localparam int          CLK_PERIOD  = 8;
  // three cycles per instruction plus room for stalls and reset
  localparam int          WATCHDOG    = (NUM_INST * 3 + 200) * CLK_PERIOD;
  localparam logic [31:0] LFSR_POLY   = 32'h8020_0003;

  logic                    clk;
  logic                    i_reset;
  logic                    i_inst_valid;
  logic [31:0]             i_inst;
  logic                    o_inst_ready;
  logic                    o_wb_valid;
  logic [4:0]              o_wb_rd;
  logic [rv_pkg::XLEN-1:0] o_wb_value;
  logic                    o_wb_illegal;
  logic                    i_wb_ready;

  logic [31:0] lfsr;
  logic [4:0]  last_rd;
  int          sent;
  int          accepted;
  int          retired;
  int          value_errors;
  int          other_errors;
  // expected results as {rd, value, illegal}
  logic [37:0] exp_q [$];

  int_core #(
    .RESET_VALUE (RESET_VALUE)
  ) u_dut (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst_ready (o_inst_ready),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd      (o_wb_rd),
    .o_wb_value   (o_wb_value),
    .o_wb_illegal (o_wb_illegal),
    .i_wb_ready   (i_wb_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
    end
    return r;
  endfunction

  // low registers favored so dependencies are common
  function automatic logic [4:0] pick_reg();
    logic [4:0] r;
    if (rand_bits(2) != 0)
      r = 5'(rand_bits(3));
    else
      r = 5'(rand_bits(5));
    return r;
  endfunction

  function automatic logic [31:0] gen_inst();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [6:0]  opc;
    logic [31:0] word;
    kind = 3'(rand_bits(3));
    f3   = 3'(rand_bits(3));
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    // chain on the previous destination
    if (rand_bits(1) == 1)
      rs1 = last_rd;
    if (rand_bits(2) == 0)
      rs2 = last_rd;
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) == 1) ? 7'h20 : 7'h00;
    case (kind)
      3'd0: begin
        // unknown opcode, or an OP word with a bad funct7
        if (rand_bits(1) == 1) begin
          opc = {5'(rand_bits(5)), 2'b11};
          if (opc == rv_pkg::OPC_OP || opc == rv_pkg::OPC_OP_IMM || opc == rv_pkg::OPC_LUI)
            opc = 7'b1100011;
          word = {25'(rand_bits(25)), opc};
        end else begin
          word = {7'h40, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
        end
      end
      3'd5, 3'd6: begin
        imm = 12'(rand_bits(12));
        // shifts take funct7 and shamt in the immediate
        if (f3 == 3'd1 || f3 == 3'd5)
          imm = {f7, rs2};
        word = {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
      end
      3'd7: word = {20'(rand_bits(20)), rd, rv_pkg::OPC_LUI};
      default: word = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endcase
    last_rd = rd;
    return word;
  endfunction

  // everything is sampled half a cycle before the edge it acts on
  always @(negedge clk) begin : scoreboard
    logic [4:0]  exp_rd;
    logic [31:0] exp_value;
    logic        exp_illegal;
    logic [37:0] head;
    logic        exp_ready;
    if (!i_reset) begin
      // input stalls only with all three registers full and the output blocked
      exp_ready = (accepted - retired < 3) || i_wb_ready;
      assert (o_inst_ready == exp_ready) else begin
        value_errors++;
        $display("FAIL o_inst_ready: got %h expected %h", o_inst_ready, exp_ready);
      end
    end
    if (!i_reset && o_wb_valid && i_wb_ready) begin
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("result for rd %0d came out with no instruction outstanding", o_wb_rd);
      end
      if (exp_q.size() != 0) begin
        head = exp_q.pop_front();
        assert (o_wb_rd == head[37:33]) else begin
          value_errors++;
          $display("FAIL o_wb_rd: got %h expected %h", o_wb_rd, head[37:33]);
        end
        assert (o_wb_value == head[32:1]) else begin
          value_errors++;
          $display("FAIL o_wb_value: got %h expected %h", o_wb_value, head[32:1]);
        end
        assert (o_wb_illegal == head[0]) else begin
          value_errors++;
          $display("FAIL o_wb_illegal: got %h expected %h", o_wb_illegal, head[0]);
        end
        // first result adds two registers still at their reset value
        if (retired == 0) begin
          assert (o_wb_value == RESET_VALUE + RESET_VALUE) else begin
            value_errors++;
            $display("FAIL o_wb_value: got %h expected %h", o_wb_value,
                     RESET_VALUE + RESET_VALUE);
          end
        end
      end
      retired++;
    end
    if (!i_reset && i_inst_valid && o_inst_ready) begin
      step_model(i_inst, exp_rd, exp_value, exp_illegal);
      exp_q.push_back({exp_rd, exp_value, exp_illegal});
      accepted++;
    end
  end

  initial begin : stimulus
    logic took;
    clk          = 1'b0;
    i_reset      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_wb_ready   = 1'b0;
    lfsr         = 32'h3900e1dd;
    last_rd      = 5'd5;
    sent         = 0;
    accepted     = 0;
    retired      = 0;
    value_errors = 0;
    other_errors = 0;
    load_reset_regs(u_dut.RESET_VALUE);
    repeat (10) @(posedge clk);
    #1;
    i_reset      = 1'b0;
    i_wb_ready   = 1'b1;
    // add x5, x3, x4
    i_inst       = {7'h00, 5'd4, 5'd3, 3'd0, 5'd5, rv_pkg::OPC_OP};
    i_inst_valid = 1'b1;
    sent         = 1;
    while (retired < NUM_INST) begin
      @(negedge clk);
      took = i_inst_valid && o_inst_ready;
      @(posedge clk);
      #1;
      if (took)
        i_inst_valid = 1'b0;
      if (!i_inst_valid && sent < NUM_INST && rand_bits(2) != 0) begin
        i_inst       = gen_inst();
        i_inst_valid = 1'b1;
        sent++;
      end
      i_wb_ready = (rand_bits(2) != 0);
    end
    // drain so that any duplicate shows up
    i_wb_ready = 1'b1;
    repeat (20) @(posedge clk);
    assert (accepted == NUM_INST && retired == NUM_INST) else begin
      other_errors++;
      $display("accepted %0d and retired %0d instructions, expected %0d of each",
               accepted, retired, NUM_INST);
    end
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("%0d expected results never came out", exp_q.size());
    end
    $display("checked %0d results: %0d value errors, %0d other errors",
             retired, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG);
    $display("watchdog expired with %0d of %0d instructions retired", retired, NUM_INST);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+dv
logic/rv_pkg.sv
logic/stage_if.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/writeback_stage.sv
logic/int_core.sv
dv/int_core_chk.sv
dv/int_core_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module int_core_tb -f all.f \
  && ./obj_dir/Vint_core_tb 2>&1 | tee sim.log \
  && grep -q "RESULT: PASS" sim.log \
  && ! grep -q "RESULT: FAIL" sim.log \
  && echo "simulation passed" \
  || {
    echo "simulation failed"
    exit 1
  }
